// ==== cluster.f ====
+incdir+verilog
verilog/cluster_pkg.sv
verilog/elastic_buf.sv
verilog/mem_arb.sv
verilog/copy_core.sv
verilog/cluster.sv
sim/cluster_chk.sv
sim/cluster_tb.sv

// ==== sim/cluster_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cluster_macros.svh"

module cluster_chk import cluster_pkg::*; (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  mem_req_valid,
    input logic                  mem_req_rw,
    input addr_t                 mem_req_addr,
    input data_t                 mem_req_data,
    input mem_tag_t              mem_req_tag,
    input logic                  mem_req_ready,
    input logic                  mem_rsp_valid,
    input mem_tag_t              mem_rsp_tag,
    input logic [`NUM_CORES-1:0] core_busy,
    input logic                  busy
);

    int failures = 0;

    // Request held until the memory takes it
    req_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req_rw)
            && $stable(mem_req_addr) && $stable(mem_req_data) && $stable(mem_req_tag))
    else begin
        failures++;
        $error("mem_req payload changed before transfer");
    end

    // A response belongs to a core that still runs its job
    rsp_core_idx: assert property (@(posedge clk) disable iff (!rst_n)
        mem_rsp_valid |-> (int'(mem_rsp_tag[`MEM_TAG_WIDTH-1:`CORE_TAG_WIDTH]) < `NUM_CORES)
            && core_busy[mem_rsp_tag[`MEM_TAG_WIDTH-1:`CORE_TAG_WIDTH]])
    else begin
        failures++;
        $error("response tag names a core that is not running a job");
    end

    idle_after_reset: assert property (@(posedge clk) !rst_n |=> !busy)
    else begin
        failures++;
        $error("busy high in the cycle after reset");
    end

endmodule

bind cluster cluster_chk chk (
    .clk           (clk),
    .rst_n         (rst_n),
    .mem_req_valid (mem_req_valid),
    .mem_req_rw    (mem_req_rw),
    .mem_req_addr  (mem_req_addr),
    .mem_req_data  (mem_req_data),
    .mem_req_tag   (mem_req_tag),
    .mem_req_ready (mem_req_ready),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp_tag   (mem_rsp_tag),
    .core_busy     (core_busy),
    .busy          (busy)
);

`default_nettype wire

// ==== sim/cluster_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cluster_macros.svh"

module cluster_tb import cluster_pkg::*; ();

    localparam int CLK_HALF   = 10;
    localparam int MAX_WORDS  = `NUM_CORES * (1 << `CORE_TAG_WIDTH);
    localparam int BUSY_LIMIT = 5000;
    localparam int NUM_JOBS   = 3;

    logic                       clk;
    logic                       rst_n;
    logic                       dcr_wr_valid;
    logic [`DCR_ADDR_WIDTH-1:0] dcr_wr_addr;
    data_t                      dcr_wr_data;
    logic                       mem_req_valid;
    logic                       mem_req_rw;
    addr_t                      mem_req_addr;
    data_t                      mem_req_data;
    mem_tag_t                   mem_req_tag;
    logic                       mem_req_ready;
    logic                       mem_rsp_valid;
    data_t                      mem_rsp_data;
    mem_tag_t                   mem_rsp_tag;
    logic                       mem_rsp_ready;
    logic                       busy;

    data_t       mem [0:(1 << `ADDR_WIDTH)-1];
    data_t       src_vals [MAX_WORDS];
    addr_t       job_src;
    addr_t       job_dst;
    data_t       job_incr;
    int          job_words;
    int          job_cnt;
    int          errors;
    int          total_errors;
    int          reads_issued;
    int          rsp_returned;
    int          writes_accepted;
    int          cyc;
    logic        rsp_taken;
    logic [31:0] stim_lfsr;
    logic [31:0] mem_lfsr;

    // Pending read responses in answer order
    data_t    rq_data [$];
    mem_tag_t rq_tag  [$];
    int       rq_due  [$];

    cluster dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .dcr_wr_valid  (dcr_wr_valid),
        .dcr_wr_addr   (dcr_wr_addr),
        .dcr_wr_data   (dcr_wr_data),
        .mem_req_valid (mem_req_valid),
        .mem_req_rw    (mem_req_rw),
        .mem_req_addr  (mem_req_addr),
        .mem_req_data  (mem_req_data),
        .mem_req_tag   (mem_req_tag),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .mem_rsp_tag   (mem_rsp_tag),
        .mem_rsp_ready (mem_rsp_ready),
        .busy          (busy)
    );

    // 32 bit Fibonacci LFSR with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] lfsr_take(inout logic [31:0] state, input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb    = state[31] ^ state[21] ^ state[1] ^ state[0];
            state = {state[30:0], fb};
            r     = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic dst_contains(input addr_t a);
        return int'(addr_t'(a - job_dst)) < job_words;
    endfunction

    // Core index above the word index of the slice
    function automatic mem_tag_t read_tag_of(input addr_t a);
        int off;
        off = int'(addr_t'(a - job_src));
        return mem_tag_t'(((off / job_cnt) << `CORE_TAG_WIDTH) + (off % job_cnt));
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic abort_run(input string what);
        $display("timeout: %s", what);
        $display("errors: %0d", errors + 1);
        $display("Simulation FAILED");
        $finish;
    endtask

    task automatic write_reg(input logic [`DCR_ADDR_WIDTH-1:0] a, input data_t d);
        dcr_wr_valid = 1'b1;
        dcr_wr_addr  = a;
        dcr_wr_data  = d;
        @(negedge clk);
        dcr_wr_valid = 1'b0;
    endtask

    task automatic run_job(input int j);
        int cnt;
        int n;
        int cycles;
        cnt       = 1 + int'(lfsr_take(stim_lfsr, 4));
        n         = `NUM_CORES * cnt;
        job_src   = addr_t'(32'h0100 + j * 32'h1000 + lfsr_take(stim_lfsr, 8));
        job_dst   = addr_t'(32'h0800 + j * 32'h1000 + lfsr_take(stim_lfsr, 8));
        job_incr  = lfsr_take(stim_lfsr, 32);
        job_words = n;
        job_cnt   = cnt;
        for (int i = 0; i < n; i++) begin
            src_vals[i]                = lfsr_take(stim_lfsr, 32);
            mem[job_src + addr_t'(i)]  = src_vals[i];
        end
        reads_issued    = 0;
        rsp_returned    = 0;
        writes_accepted = 0;
        write_reg(`REG_SRC_BASE, data_t'(job_src));
        write_reg(`REG_DST_BASE, data_t'(job_dst));
        write_reg(`REG_COUNT, data_t'(cnt));
        write_reg(`REG_INCR, job_incr);
        dcr_wr_valid = 1'b1;
        dcr_wr_addr  = `REG_START;
        dcr_wr_data  = '0;
        check(busy, 0, "busy before start");
        @(negedge clk);
        dcr_wr_valid = 1'b0;
        check(busy, 1, "busy one cycle after start");
        cycles = 0;
        while (busy && cycles < BUSY_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            abort_run("busy still high long after job start");
        end
        check(writes_accepted, n, "writes accepted when busy fell");
        check(reads_issued, n, "read requests issued");
        check(rsp_returned, reads_issued, "read responses returned");
        for (int i = 0; i < n; i++) begin
            check(mem[job_dst + addr_t'(i)], src_vals[i] + job_incr, "destination word");
            check(mem[job_src + addr_t'(i)], src_vals[i], "source word");
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // Memory model drives at the falling edge and samples just after
    initial begin
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_data  = '0;
        mem_rsp_tag   = '0;
        mem_lfsr      = 32'd2;
        rsp_taken     = 1'b0;
        cyc           = 0;
        forever begin
            @(negedge clk);
            cyc++;
            if (rsp_taken) begin
                mem_rsp_valid = 1'b0;
            end
            mem_req_ready = (lfsr_take(mem_lfsr, 2) != 0);
            if (!mem_rsp_valid && rq_due.size() > 0 && rq_due[0] <= cyc) begin
                if (lfsr_take(mem_lfsr, 2) != 0) begin
                    mem_rsp_valid = 1'b1;
                    mem_rsp_data  = rq_data[0];
                    mem_rsp_tag   = rq_tag[0];
                end
            end
            #1;
            rsp_taken = mem_rsp_valid && mem_rsp_ready;
            if (rsp_taken) begin
                void'(rq_data.pop_front());
                void'(rq_tag.pop_front());
                void'(rq_due.pop_front());
                rsp_returned++;
            end
            if (mem_req_valid && mem_req_ready) begin
                if (mem_req_rw) begin
                    check(dst_contains(mem_req_addr), 1, "write address in destination range");
                    mem[mem_req_addr] = mem_req_data;
                    writes_accepted++;
                end else begin
                    check(mem_req_tag, read_tag_of(mem_req_addr), "read request tag");
                    rq_data.push_back(mem[mem_req_addr]);
                    rq_tag.push_back(mem_req_tag);
                    rq_due.push_back(cyc + 1 + int'(lfsr_take(mem_lfsr, 3)));
                    reads_issued++;
                end
            end
        end
    end

    initial begin
        rst_n        = 1'b0;
        dcr_wr_valid = 1'b0;
        dcr_wr_addr  = '0;
        dcr_wr_data  = '0;
        errors       = 0;
        job_cnt      = 1;
        stim_lfsr    = 32'd2;
        for (int a = 0; a < (1 << `ADDR_WIDTH); a++) begin
            mem[a] = {~a[15:0], a[15:0]};
        end
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        check(busy, 0, "busy after reset");
        check(mem_req_valid, 0, "mem_req_valid after reset");
        check(mem_rsp_ready, 0, "mem_rsp_ready after reset");
        for (int j = 0; j < NUM_JOBS; j++) begin
            run_job(j);
        end
        total_errors = errors + dut.chk.failures;
        $display("errors: %0d (assertion failures %0d)", total_errors, dut.chk.failures);
        if (total_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/cluster.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cluster_macros.svh"

module cluster import cluster_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,

    input  logic                       dcr_wr_valid,
    input  logic [`DCR_ADDR_WIDTH-1:0] dcr_wr_addr,
    input  data_t                      dcr_wr_data,

    output logic                       mem_req_valid,
    output logic                       mem_req_rw,
    output addr_t                      mem_req_addr,
    output data_t                      mem_req_data,
    output mem_tag_t                   mem_req_tag,
    input  logic                       mem_req_ready,
    input  logic                       mem_rsp_valid,
    input  data_t                      mem_rsp_data,
    input  mem_tag_t                   mem_rsp_tag,
    output logic                       mem_rsp_ready,

    output logic                       busy
);

    logic [`NUM_CORES-1:0] core_req_valid;
    logic [`NUM_CORES-1:0] core_req_rw;
    addr_t                 core_req_addr [`NUM_CORES];
    data_t                 core_req_data [`NUM_CORES];
    core_tag_t             core_req_tag  [`NUM_CORES];
    logic [`NUM_CORES-1:0] core_req_ready;
    logic [`NUM_CORES-1:0] core_rsp_valid;
    data_t                 core_rsp_data [`NUM_CORES];
    core_tag_t             core_rsp_tag  [`NUM_CORES];
    logic [`NUM_CORES-1:0] core_rsp_ready;
    logic [`NUM_CORES-1:0] core_busy;
    logic                  arb_pending;

    for (genvar i = 0; i < `NUM_CORES; i++) begin : g_core
        copy_core #(
            .CORE_ID (i)
        ) core (
            .clk           (clk),
            .rst_n         (rst_n),
            .dcr_wr_valid  (dcr_wr_valid),
            .dcr_wr_addr   (dcr_wr_addr),
            .dcr_wr_data   (dcr_wr_data),
            .mem_req_valid (core_req_valid[i]),
            .mem_req_rw    (core_req_rw[i]),
            .mem_req_addr  (core_req_addr[i]),
            .mem_req_data  (core_req_data[i]),
            .mem_req_tag   (core_req_tag[i]),
            .mem_req_ready (core_req_ready[i]),
            .mem_rsp_valid (core_rsp_valid[i]),
            .mem_rsp_data  (core_rsp_data[i]),
            .mem_rsp_tag   (core_rsp_tag[i]),
            .mem_rsp_ready (core_rsp_ready[i]),
            .busy          (core_busy[i])
        );
    end

    mem_arb #(
        .NUM_REQS (`NUM_CORES)
    ) arb (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_in_valid  (core_req_valid),
        .req_in_rw     (core_req_rw),
        .req_in_addr   (core_req_addr),
        .req_in_data   (core_req_data),
        .req_in_tag    (core_req_tag),
        .req_in_ready  (core_req_ready),
        .rsp_out_valid (core_rsp_valid),
        .rsp_out_data  (core_rsp_data),
        .rsp_out_tag   (core_rsp_tag),
        .rsp_out_ready (core_rsp_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req_rw    (mem_req_rw),
        .mem_req_addr  (mem_req_addr),
        .mem_req_data  (mem_req_data),
        .mem_req_tag   (mem_req_tag),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .mem_rsp_tag   (mem_rsp_tag),
        .mem_rsp_ready (mem_rsp_ready),
        .pending       (arb_pending)
    );

    // Busy until the last write has left the arbiter
    assign busy = (|core_busy) || arb_pending;

endmodule

`default_nettype wire

// ==== verilog/cluster_macros.svh ====
`ifndef CLUSTER_MACROS_SVH
`define CLUSTER_MACROS_SVH

// Cluster sizing
`define NUM_CORES        4
`define ADDR_WIDTH       16
`define DATA_WIDTH       32

// Core tag holds the word index, so 16 words per core at most
`define CORE_TAG_WIDTH   4
// Core tag plus two bits of core index
`define MEM_TAG_WIDTH    6

`define MAX_OUTSTANDING  4

// Configuration bus
`define DCR_ADDR_WIDTH   3

`define REG_SRC_BASE     3'd0
`define REG_DST_BASE     3'd1
`define REG_COUNT        3'd2
`define REG_INCR         3'd3
`define REG_START        3'd4

`endif

// ==== verilog/cluster_pkg.sv ====
`default_nettype none

`include "cluster_macros.svh"

package cluster_pkg;

    typedef logic [`ADDR_WIDTH-1:0]     addr_t;
    typedef logic [`DATA_WIDTH-1:0]     data_t;
    typedef logic [`CORE_TAG_WIDTH-1:0] core_tag_t;
    typedef logic [`MEM_TAG_WIDTH-1:0]  mem_tag_t;

    // rw is high for a write
    typedef struct packed {
        logic     rw;
        addr_t    addr;
        data_t    data;
        mem_tag_t tag;
    } mem_req_t;

    typedef struct packed {
        data_t    data;
        mem_tag_t tag;
    } mem_rsp_t;

endpackage

`default_nettype wire

// ==== verilog/copy_core.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cluster_macros.svh"

module copy_core import cluster_pkg::*; #(
    parameter int CORE_ID = 0
) (
    input  logic                       clk,
    input  logic                       rst_n,

    // Configuration writes
    input  logic                       dcr_wr_valid,
    input  logic [`DCR_ADDR_WIDTH-1:0] dcr_wr_addr,
    input  data_t                      dcr_wr_data,

    // Memory request
    output logic                       mem_req_valid,
    output logic                       mem_req_rw,
    output addr_t                      mem_req_addr,
    output data_t                      mem_req_data,
    output core_tag_t                  mem_req_tag,
    input  logic                       mem_req_ready,

    // Memory response
    input  logic                       mem_rsp_valid,
    input  data_t                      mem_rsp_data,
    input  core_tag_t                  mem_rsp_tag,
    output logic                       mem_rsp_ready,

    output logic                       busy
);

    localparam int CNT_WIDTH = `CORE_TAG_WIDTH + 1;
    localparam int Q_AW      = $clog2(`MAX_OUTSTANDING);
    localparam int INF_WIDTH = $clog2(`MAX_OUTSTANDING + 1);

    addr_t                src_base;
    addr_t                dst_base;
    logic [CNT_WIDTH-1:0] count;
    data_t                incr;
    addr_t                rd_base;
    addr_t                wr_base;
    logic [CNT_WIDTH-1:0] rd_idx;
    logic [CNT_WIDTH-1:0] wr_done;
    logic [INF_WIDTH-1:0] inflight;
    logic                 start;

    // Write queue of finished words
    core_tag_t            q_tag  [`MAX_OUTSTANDING];
    data_t                q_data [`MAX_OUTSTANDING];
    logic [Q_AW-1:0]      q_wp;
    logic [Q_AW-1:0]      q_rp;
    logic [Q_AW:0]        q_count;
    logic                 q_push;
    logic                 q_pop;

    logic                 req_load;
    logic                 pick_wr;
    logic                 pick_rd;
    logic                 wr_fire;

    always_ff @(posedge clk) begin
        if (dcr_wr_valid) begin
            case (dcr_wr_addr)
                `REG_SRC_BASE: src_base <= addr_t'(dcr_wr_data);
                `REG_DST_BASE: dst_base <= addr_t'(dcr_wr_data);
                `REG_COUNT:    count    <= CNT_WIDTH'(dcr_wr_data);
                `REG_INCR:     incr     <= dcr_wr_data;
                default: ;
            endcase
        end
    end

    assign start = dcr_wr_valid && (dcr_wr_addr == `REG_START) && !busy;

    // Request register loads whenever the port is idle or draining
    assign req_load = !mem_req_valid || mem_req_ready;
    assign pick_wr  = (q_count != 0);
    assign pick_rd  = !pick_wr && busy && (rd_idx < count) && (inflight < `MAX_OUTSTANDING);
    assign wr_fire  = mem_req_valid && mem_req_ready && mem_req_rw;

    assign q_push = mem_rsp_valid && mem_rsp_ready;
    assign q_pop  = pick_wr && req_load;
    assign mem_rsp_ready = (q_count != (Q_AW+1)'(`MAX_OUTSTANDING));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            rd_idx   <= '0;
            wr_done  <= '0;
            inflight <= '0;
        end else begin
            if (start) begin
                busy    <= 1'b1;
                rd_idx  <= '0;
                wr_done <= '0;
            end else begin
                if (busy && (wr_done == count)) begin
                    busy <= 1'b0;
                end
                if (pick_rd && req_load) begin
                    rd_idx <= rd_idx + 1'b1;
                end
                if (wr_fire) begin
                    wr_done <= wr_done + 1'b1;
                end
            end
            // Reads count from issue until their write leaves
            case ({pick_rd && req_load, wr_fire})
                2'b10:   inflight <= inflight + 1'b1;
                2'b01:   inflight <= inflight - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rd_base <= src_base + addr_t'(CORE_ID) * addr_t'(count);
            wr_base <= dst_base + addr_t'(CORE_ID) * addr_t'(count);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q_wp    <= '0;
            q_rp    <= '0;
            q_count <= '0;
        end else begin
            if (q_push) begin
                q_wp <= q_wp + 1'b1;
            end
            if (q_pop) begin
                q_rp <= q_rp + 1'b1;
            end
            q_count <= q_count + (Q_AW+1)'(q_push) - (Q_AW+1)'(q_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (q_push) begin
            q_tag[q_wp]  <= mem_rsp_tag;
            q_data[q_wp] <= mem_rsp_data + incr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_req_valid <= 1'b0;
        end else if (req_load) begin
            mem_req_valid <= pick_wr || pick_rd;
        end
    end

    // Pending writes take the port before new reads
    always_ff @(posedge clk) begin
        if (req_load) begin
            if (pick_wr) begin
                mem_req_rw   <= 1'b1;
                mem_req_addr <= wr_base + addr_t'(q_tag[q_rp]);
                mem_req_data <= q_data[q_rp];
                mem_req_tag  <= q_tag[q_rp];
            end else if (pick_rd) begin
                mem_req_rw   <= 1'b0;
                mem_req_addr <= rd_base + addr_t'(rd_idx);
                mem_req_data <= '0;
                mem_req_tag  <= core_tag_t'(rd_idx);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/elastic_buf.sv ====
`timescale 1ns/1ns
`default_nettype none

module elastic_buf #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready,
    output logic     empty
);

    logic     skid_valid;
    payload_t skid_data;
    logic     in_fire;
    logic     out_free;

    // Ready depends only on the skid slot, so it is a flop output
    assign in_ready = !skid_valid;
    assign in_fire  = in_valid && in_ready;
    assign out_free = out_ready || !out_valid;
    assign empty    = !out_valid && !skid_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            out_valid  <= skid_valid || in_fire;
            skid_valid <= 1'b0;
        end else if (in_fire) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            if (skid_valid) begin
                out_data <= skid_data;
            end else if (in_fire) begin
                out_data <= in_data;
            end
        end
        // Park the new word while the output is stalled
        if (in_fire && !out_free) begin
            skid_data <= in_data;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/mem_arb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "cluster_macros.svh"

module mem_arb import cluster_pkg::*; #(
    parameter int NUM_REQS = 4
) (
    input  logic                clk,
    input  logic                rst_n,

    // Requester side
    input  logic [NUM_REQS-1:0] req_in_valid,
    input  logic [NUM_REQS-1:0] req_in_rw,
    input  addr_t               req_in_addr [NUM_REQS],
    input  data_t               req_in_data [NUM_REQS],
    input  core_tag_t           req_in_tag  [NUM_REQS],
    output logic [NUM_REQS-1:0] req_in_ready,
    output logic [NUM_REQS-1:0] rsp_out_valid,
    output data_t               rsp_out_data [NUM_REQS],
    output core_tag_t           rsp_out_tag  [NUM_REQS],
    input  logic [NUM_REQS-1:0] rsp_out_ready,

    // Memory side
    output logic                mem_req_valid,
    output logic                mem_req_rw,
    output addr_t               mem_req_addr,
    output data_t               mem_req_data,
    output mem_tag_t            mem_req_tag,
    input  logic                mem_req_ready,
    input  logic                mem_rsp_valid,
    input  data_t               mem_rsp_data,
    input  mem_tag_t            mem_rsp_tag,
    output logic                mem_rsp_ready,

    output logic                pending
);

    localparam int IDX_WIDTH = `MEM_TAG_WIDTH - `CORE_TAG_WIDTH;

    mem_req_t              q_req [NUM_REQS];
    logic [NUM_REQS-1:0]   q_valid;
    logic [NUM_REQS-1:0]   q_ready;
    logic [NUM_REQS-1:0]   q_empty;
    mem_rsp_t              rsp_buf [NUM_REQS];
    logic [NUM_REQS-1:0]   rsp_in_valid;
    logic [NUM_REQS-1:0]   rsp_in_ready;
    logic [NUM_REQS-1:0]   rsp_empty;
    logic [IDX_WIDTH-1:0]  rr_ptr;
    logic [IDX_WIDTH-1:0]  grant_idx;
    logic                  grant_valid;
    mem_req_t              sel_req;
    mem_req_t              out_req;
    logic                  out_in_ready;
    logic                  out_empty;
    logic [IDX_WIDTH-1:0]  rsp_idx;
    mem_rsp_t              rsp_in;

    for (genvar i = 0; i < NUM_REQS; i++) begin : g_req
        mem_req_t in_req;

        // Tag enters zero extended and gets its index at the grant
        assign in_req = '{rw: req_in_rw[i], addr: req_in_addr[i],
                          data: req_in_data[i], tag: mem_tag_t'(req_in_tag[i])};

        elastic_buf #(.payload_t(mem_req_t)) req_buf (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (req_in_valid[i]),
            .in_data   (in_req),
            .in_ready  (req_in_ready[i]),
            .out_valid (q_valid[i]),
            .out_data  (q_req[i]),
            .out_ready (q_ready[i]),
            .empty     (q_empty[i])
        );

        assign q_ready[i] = out_in_ready && grant_valid && (grant_idx == IDX_WIDTH'(i));
    end

    // Round robin search starting at rr_ptr
    always_comb begin
        int cand;
        grant_valid = 1'b0;
        grant_idx   = '0;
        for (int k = 0; k < NUM_REQS; k++) begin
            cand = (int'(rr_ptr) + k) % NUM_REQS;
            if (!grant_valid && q_valid[cand]) begin
                grant_valid = 1'b1;
                grant_idx   = IDX_WIDTH'(cand);
            end
        end
    end

    always_comb begin
        sel_req     = q_req[grant_idx];
        sel_req.tag = {grant_idx, q_req[grant_idx].tag[`CORE_TAG_WIDTH-1:0]};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rr_ptr <= '0;
        end else if (grant_valid && out_in_ready) begin
            rr_ptr <= IDX_WIDTH'((int'(grant_idx) + 1) % NUM_REQS);
        end
    end

    elastic_buf #(.payload_t(mem_req_t)) out_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (grant_valid),
        .in_data   (sel_req),
        .in_ready  (out_in_ready),
        .out_valid (mem_req_valid),
        .out_data  (out_req),
        .out_ready (mem_req_ready),
        .empty     (out_empty)
    );

    assign mem_req_rw   = out_req.rw;
    assign mem_req_addr = out_req.addr;
    assign mem_req_data = out_req.data;
    assign mem_req_tag  = out_req.tag;

    // Steer responses by the top tag bits
    assign rsp_idx = mem_rsp_tag[`MEM_TAG_WIDTH-1:`CORE_TAG_WIDTH];
    assign rsp_in  = '{data: mem_rsp_data,
                       tag: mem_tag_t'(mem_rsp_tag[`CORE_TAG_WIDTH-1:0])};

    for (genvar i = 0; i < NUM_REQS; i++) begin : g_rsp
        assign rsp_in_valid[i] = mem_rsp_valid && (rsp_idx == IDX_WIDTH'(i));

        elastic_buf #(.payload_t(mem_rsp_t)) rsp_buf_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (rsp_in_valid[i]),
            .in_data   (rsp_in),
            .in_ready  (rsp_in_ready[i]),
            .out_valid (rsp_out_valid[i]),
            .out_data  (rsp_buf[i]),
            .out_ready (rsp_out_ready[i]),
            .empty     (rsp_empty[i])
        );

        assign rsp_out_data[i] = rsp_buf[i].data;
        assign rsp_out_tag[i]  = rsp_buf[i].tag[`CORE_TAG_WIDTH-1:0];
    end

    assign mem_rsp_ready = |(rsp_in_valid & rsp_in_ready);

    assign pending = !(&q_empty) || !out_empty || !(&rsp_empty);

endmodule

`default_nettype wire
